// File: design/idu_pkg.sv
// decode stage shared definitions: widths, opcode and control enums, decode structs
package idu_pkg;

  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int PC_STEP    = 4;

  // branch funct3 codes
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    TYPE_I = 3'b000,
    TYPE_U = 3'b001,
    TYPE_S = 3'b010,
    TYPE_J = 3'b011,
    TYPE_B = 3'b100,
    TYPE_R = 3'b101
  } inst_type_e;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_PASS_IMM
  } alu_op_e;

  typedef enum logic {
    SRC2_REG = 1'b0,
    SRC2_IMM = 1'b1
  } src2_sel_e;

  typedef enum logic [1:0] {
    WD_ALU  = 2'b00,
    WD_LOAD = 2'b01,
    WD_PC4  = 2'b10
  } wd_sel_e;

  typedef enum logic [1:0] {
    PC_SEQ     = 2'b00,
    PC_PC_IMM  = 2'b01,
    PC_REG_IMM = 2'b10
  } pc_sel_e;

  typedef struct packed {
    inst_type_e inst_type;
    alu_op_e    alu_op;
    logic       src1_is_pc;
    src2_sel_e  src2_sel;
    wd_sel_e    wd_sel;
    pc_sel_e    pc_sel;
    logic       is_branch;
    logic [2:0] branch_funct3;
    logic       ren;
    logic       wen;
    logic [3:0] wmask;
    logic [31:0] rmask;
    logic       load_signed;
    logic       reg_write;
  } decode_ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0]       pc;
    logic [XLEN-1:0]       src1;
    logic [XLEN-1:0]       src2;
    logic [XLEN-1:0]       imm;
    logic [REG_ADDR_W-1:0] rd;
    alu_op_e               alu_op;
    wd_sel_e               wd_sel;
    logic                  ren;
    logic                  wen;
    logic [3:0]            wmask;
    logic [31:0]           rmask;
    logic                  load_signed;
    logic                  reg_write;
    logic [XLEN-1:0]       pc_next;
  } dec_out_t;

endpackage

// File: design/imm_gen.sv
// immediate generator, sign-extends the immediate of each RV32I format
`timescale 1ns/1ps

module imm_gen import idu_pkg::*; (
  input  logic [XLEN-1:0] inst_i,
  input  inst_type_e      type_i,
  output logic [XLEN-1:0] imm_o
);

  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_b;

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  // offsets in halfwords, bit 0 always zero
  assign imm_j = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};
  assign imm_b = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};

  always_comb begin
    case (type_i)
      TYPE_I:  imm_o = imm_i;
      TYPE_U:  imm_o = imm_u;
      TYPE_S:  imm_o = imm_s;
      TYPE_J:  imm_o = imm_j;
      TYPE_B:  imm_o = imm_b;
      default: imm_o = '0;
    endcase
  end

endmodule

// File: design/inst_decoder.sv
// instruction decoder, turns opcode/funct3/funct7 into the decode control bundle
`timescale 1ns/1ps

module inst_decoder import idu_pkg::*; (
  input  logic [XLEN-1:0] inst_i,
  output inst_type_e      type_o,
  output decode_ctrl_t    ctrl_o
);

  opcode_e    opcode;
  logic [2:0] funct3;
  logic       funct7_alt;

  assign opcode     = opcode_e'(inst_i[6:0]);
  assign funct3     = inst_i[14:12];
  assign funct7_alt = inst_i[30];

  // alt_add only applies to register ops, imm ops carry immediate bits there
  function automatic alu_op_e alu_decode(input logic [2:0] f3,
                                         input logic alt_add,
                                         input logic alt_shift);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt_add ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt_shift ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  always_comb begin
    ctrl_o           = '0;
    ctrl_o.inst_type = TYPE_R;
    ctrl_o.alu_op    = ALU_ADD;
    ctrl_o.src2_sel  = SRC2_REG;
    ctrl_o.wd_sel    = WD_ALU;
    ctrl_o.pc_sel    = PC_SEQ;
    case (opcode)
      OPC_LUI: begin
        ctrl_o.inst_type = TYPE_U;
        ctrl_o.alu_op    = ALU_PASS_IMM;
        ctrl_o.src2_sel  = SRC2_IMM;
        ctrl_o.reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        ctrl_o.inst_type  = TYPE_U;
        ctrl_o.src1_is_pc = 1'b1;
        ctrl_o.src2_sel   = SRC2_IMM;
        ctrl_o.reg_write  = 1'b1;
      end
      OPC_JAL: begin
        ctrl_o.inst_type  = TYPE_J;
        ctrl_o.src1_is_pc = 1'b1;
        ctrl_o.src2_sel   = SRC2_IMM;
        ctrl_o.wd_sel     = WD_PC4;
        ctrl_o.pc_sel     = PC_PC_IMM;
        ctrl_o.reg_write  = 1'b1;
      end
      OPC_JALR: begin
        ctrl_o.inst_type = TYPE_I;
        ctrl_o.src2_sel  = SRC2_IMM;
        ctrl_o.wd_sel    = WD_PC4;
        ctrl_o.pc_sel    = PC_REG_IMM;
        ctrl_o.reg_write = 1'b1;
      end
      OPC_BRANCH: begin
        ctrl_o.inst_type     = TYPE_B;
        ctrl_o.is_branch     = 1'b1;
        ctrl_o.branch_funct3 = funct3;
        ctrl_o.pc_sel        = PC_PC_IMM;
        // compare op for the execute side
        if (funct3[2]) begin
          ctrl_o.alu_op = funct3[1] ? ALU_SLTU : ALU_SLT;
        end else begin
          ctrl_o.alu_op = ALU_SUB;
        end
      end
      OPC_LOAD: begin
        ctrl_o.inst_type   = TYPE_I;
        ctrl_o.src2_sel    = SRC2_IMM;
        ctrl_o.ren         = 1'b1;
        ctrl_o.wd_sel      = WD_LOAD;
        ctrl_o.reg_write   = 1'b1;
        ctrl_o.load_signed = (funct3 == 3'b000) || (funct3 == 3'b001);
        case (funct3[1:0])
          2'b00:   ctrl_o.rmask = 32'h0000_00ff;
          2'b01:   ctrl_o.rmask = 32'h0000_ffff;
          default: ctrl_o.rmask = 32'hffff_ffff;
        endcase
      end
      OPC_STORE: begin
        ctrl_o.inst_type = TYPE_S;
        ctrl_o.src2_sel  = SRC2_IMM;
        ctrl_o.wen       = 1'b1;
        case (funct3[1:0])
          2'b00:   ctrl_o.wmask = 4'b0001;
          2'b01:   ctrl_o.wmask = 4'b0011;
          default: ctrl_o.wmask = 4'b1111;
        endcase
      end
      OPC_OP_IMM: begin
        ctrl_o.inst_type = TYPE_I;
        ctrl_o.alu_op    = alu_decode(funct3, 1'b0, funct7_alt);
        ctrl_o.src2_sel  = SRC2_IMM;
        ctrl_o.reg_write = 1'b1;
      end
      OPC_OP: begin
        ctrl_o.inst_type = TYPE_R;
        ctrl_o.alu_op    = alu_decode(funct3, funct7_alt, funct7_alt);
        ctrl_o.reg_write = 1'b1;
      end
      default: begin
        // unknown opcode, behaves as a nop
        ctrl_o.inst_type = TYPE_R;
      end
    endcase
  end

  assign type_o = ctrl_o.inst_type;

endmodule

// File: design/branch_unit.sv
// branch unit, resolves conditional branches and jumps into the next PC
`timescale 1ns/1ps

module branch_unit import idu_pkg::*; (
  input  decode_ctrl_t    ctrl_i,
  input  logic [XLEN-1:0] src1_i,
  input  logic [XLEN-1:0] src2_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  output logic [XLEN-1:0] pc_next_o
);

  logic    eq;
  logic    lt_s;
  logic    lt_u;
  logic    taken;
  pc_sel_e pc_sel;

  assign eq   = (src1_i == src2_i);
  assign lt_s = ($signed(src1_i) < $signed(src2_i));
  assign lt_u = (src1_i < src2_i);

  always_comb begin
    case (ctrl_i.branch_funct3)
      F3_BEQ:  taken = eq;
      F3_BNE:  taken = !eq;
      F3_BLT:  taken = lt_s;
      F3_BGE:  taken = !lt_s;
      F3_BLTU: taken = lt_u;
      F3_BGEU: taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  // not-taken branch falls through
  assign pc_sel = (ctrl_i.is_branch && !taken) ? PC_SEQ : ctrl_i.pc_sel;

  always_comb begin
    case (pc_sel)
      PC_PC_IMM:  pc_next_o = pc_i + imm_i;
      PC_REG_IMM: pc_next_o = (src1_i + imm_i) & ~XLEN'(1);
      default:    pc_next_o = pc_i + XLEN'(PC_STEP);
    endcase
  end

endmodule

// File: design/idu.sv
// decode stage top, decodes one instruction and hands it to execute via a valid/ready slot
`timescale 1ns/1ps

module idu import idu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  // fetch side
  input  logic                  inst_valid_i,
  input  logic [XLEN-1:0]       inst_i,
  input  logic [XLEN-1:0]       pc_i,
  output logic                  inst_ready_o,
  // register file
  output logic [REG_ADDR_W-1:0] rs1_addr_o,
  output logic [REG_ADDR_W-1:0] rs2_addr_o,
  input  logic [XLEN-1:0]       rs1_data_i,
  input  logic [XLEN-1:0]       rs2_data_i,
  // execute side
  output logic                  dec_valid_o,
  output dec_out_t              dec_o,
  input  logic                  dec_ready_i
);

  inst_type_e      inst_type;
  decode_ctrl_t    ctrl;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] src1;
  logic [XLEN-1:0] src2;
  logic [XLEN-1:0] pc_next;
  dec_out_t        dec_next;
  logic            accept;

  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];

  inst_decoder u_inst_decoder (
    .inst_i (inst_i),
    .type_o (inst_type),
    .ctrl_o (ctrl)
  );

  imm_gen u_imm_gen (
    .inst_i (inst_i),
    .type_i (inst_type),
    .imm_o  (imm)
  );

  // operand select
  assign src1 = ctrl.src1_is_pc ? pc_i : rs1_data_i;
  assign src2 = (ctrl.src2_sel == SRC2_IMM) ? imm : rs2_data_i;

  branch_unit u_branch_unit (
    .ctrl_i    (ctrl),
    .src1_i    (src1),
    .src2_i    (src2),
    .imm_i     (imm),
    .pc_i      (pc_i),
    .pc_next_o (pc_next)
  );

  always_comb begin
    dec_next.pc          = pc_i;
    dec_next.src1        = src1;
    dec_next.src2        = src2;
    dec_next.imm         = imm;
    dec_next.rd          = inst_i[11:7];
    dec_next.alu_op      = ctrl.alu_op;
    dec_next.wd_sel      = ctrl.wd_sel;
    dec_next.ren         = ctrl.ren;
    dec_next.wen         = ctrl.wen;
    dec_next.wmask       = ctrl.wmask;
    dec_next.rmask       = ctrl.rmask;
    dec_next.load_signed = ctrl.load_signed;
    dec_next.reg_write   = ctrl.reg_write;
    dec_next.pc_next     = pc_next;
  end

  // slot free when empty or draining this cycle
  assign inst_ready_o = !dec_valid_o || dec_ready_i;
  assign accept       = inst_valid_i && inst_ready_o;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_valid_o <= 1'b0;
      dec_o       <= '0;
    end else if (accept) begin
      dec_valid_o <= 1'b1;
      dec_o       <= dec_next;
    end else if (dec_ready_i) begin
      dec_valid_o <= 1'b0;
    end
  end

endmodule

// File: verification/tb_idu_tasks.svh
// decode stage test tasks: instruction encoders, handshake driver, compares and directed tests
`ifndef TB_IDU_TASKS_SVH
`define TB_IDU_TASKS_SVH

function automatic logic [31:0] i_format(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input opcode_e opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] r_format(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, OPC_OP};
endfunction

function automatic logic [31:0] s_format(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
endfunction

function automatic logic [31:0] b_format(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
endfunction

function automatic logic [31:0] u_format(input logic [19:0] imm, input logic [4:0] rd,
                                         input opcode_e opc);
  return {imm, rd, opc};
endfunction

function automatic logic [31:0] j_format(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
endfunction

// register-writing ALU result with sequential next PC
function automatic dec_out_t expect_alu(input logic [31:0] pc, input logic [31:0] src1,
                                        input logic [31:0] src2, input logic [31:0] imm,
                                        input logic [4:0] rd, input alu_op_e op);
  dec_out_t d;
  d           = '0;
  d.pc        = pc;
  d.src1      = src1;
  d.src2      = src2;
  d.imm       = imm;
  d.rd        = rd;
  d.alu_op    = op;
  d.wd_sel    = WD_ALU;
  d.reg_write = 1'b1;
  d.pc_next   = pc + 32'd4;
  return d;
endfunction

task automatic compare_dec(input dec_out_t got, input dec_out_t exp, input string what);
  if (got !== exp) begin
    fail_run($sformatf("mismatch at %0t: %s, dec_o %h expected %h", $time, what, got, exp));
  end
endtask

task automatic compare_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                          input string what);
  if (got !== exp) begin
    fail_run($sformatf("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp));
  end
endtask

task automatic compare_flag(input logic got, input logic exp, input string what);
  if (got !== exp) begin
    fail_run($sformatf("mismatch at %0t: %s, got %b expected %b", $time, what, got, exp));
  end
endtask

// holds the instruction until accepted, output is due one cycle later
task automatic send_inst(input logic [31:0] inst, input logic [31:0] pc);
  logic accepted;
  accepted    = 1'b0;
  fetch_valid = 1'b1;
  fetch_inst  = inst;
  fetch_pc    = pc;
  while (!accepted) begin
    @(negedge clk);
    accepted = fetch_ready;
    @(posedge clk);
    #1;
  end
  fetch_valid = 1'b0;
  compare_flag(dec_valid, 1'b1, "dec_valid_o one cycle after accept");
endtask

task automatic decode_check(input logic [31:0] inst, input logic [31:0] pc,
                            input dec_out_t exp, input string what);
  send_inst(inst, pc);
  compare_dec(dec_out, exp, what);
endtask

task automatic run_alu(input logic [31:0] inst, input logic [31:0] pc,
                       input logic [31:0] src1, input logic [31:0] src2,
                       input logic [31:0] imm, input logic [4:0] rd,
                       input alu_op_e op, input string what);
  decode_check(inst, pc, expect_alu(pc, src1, src2, imm, rd, op), what);
endtask

task automatic drain_slot();
  while (dec_valid) begin
    @(posedge clk);
    #1;
  end
endtask

task automatic reset_check();
  compare_flag(dec_valid, 1'b0, "dec_valid_o after reset");
  compare_flag(fetch_ready, 1'b1, "inst_ready_o after reset");
  compare_dec(dec_out, '0, "dec_o after reset");
endtask

task automatic itype_tests();
  run_alu(i_format(12'hffb, 5'd1, 3'b000, 5'd5, OPC_OP_IMM), 32'h100, reg_model[1],
          32'hffff_fffb, 32'hffff_fffb, 5'd5, ALU_ADD, "addi");
  run_alu(i_format(12'h0f0, 5'd2, 3'b111, 5'd6, OPC_OP_IMM), 32'h104, reg_model[2],
          32'h0000_00f0, 32'h0000_00f0, 5'd6, ALU_AND, "andi");
  run_alu(i_format(12'h004, 5'd3, 3'b001, 5'd7, OPC_OP_IMM), 32'h108, reg_model[3],
          32'h0000_0004, 32'h0000_0004, 5'd7, ALU_SLL, "slli");
  // funct7 bit 5 sits in imm bit 10 for shifts
  run_alu(i_format(12'h403, 5'd4, 3'b101, 5'd8, OPC_OP_IMM), 32'h10c, reg_model[4],
          32'h0000_0403, 32'h0000_0403, 5'd8, ALU_SRA, "srai");
  run_alu(i_format(12'hfff, 5'd1, 3'b011, 5'd9, OPC_OP_IMM), 32'h110, reg_model[1],
          32'hffff_ffff, 32'hffff_ffff, 5'd9, ALU_SLTU, "sltiu");
endtask

task automatic rtype_tests();
  run_alu(r_format(7'h00, 5'd2, 5'd1, 3'b000, 5'd10), 32'h140, reg_model[1],
          reg_model[2], 32'h0, 5'd10, ALU_ADD, "add");
  run_alu(r_format(7'h20, 5'd4, 5'd3, 3'b000, 5'd11), 32'h144, reg_model[3],
          reg_model[4], 32'h0, 5'd11, ALU_SUB, "sub");
  run_alu(r_format(7'h20, 5'd6, 5'd5, 3'b101, 5'd12), 32'h148, reg_model[5],
          reg_model[6], 32'h0, 5'd12, ALU_SRA, "sra");
  run_alu(r_format(7'h00, 5'd8, 5'd7, 3'b011, 5'd13), 32'h14c, reg_model[7],
          reg_model[8], 32'h0, 5'd13, ALU_SLTU, "sltu");
endtask

task automatic load_case(input logic [2:0] f3, input logic [11:0] off,
                         input logic [31:0] rmask, input logic sign, input string what);
  dec_out_t    exp;
  logic [31:0] imm;
  imm = {{20{off[11]}}, off};
  exp = expect_alu(32'h180, reg_model[1], imm, imm, 5'd14, ALU_ADD);
  exp.wd_sel      = WD_LOAD;
  exp.ren         = 1'b1;
  exp.rmask       = rmask;
  exp.load_signed = sign;
  decode_check(i_format(off, 5'd1, f3, 5'd14, OPC_LOAD), 32'h180, exp, what);
endtask

task automatic store_case(input logic [2:0] f3, input logic [11:0] off,
                          input logic [3:0] wmask, input string what);
  dec_out_t    exp;
  logic [31:0] imm;
  imm = {{20{off[11]}}, off};
  // the rd slot of a store carries imm[4:0]
  exp = expect_alu(32'h190, reg_model[2], imm, imm, off[4:0], ALU_ADD);
  exp.wen       = 1'b1;
  exp.wmask     = wmask;
  exp.reg_write = 1'b0;
  decode_check(s_format(off, 5'd3, 5'd2, f3), 32'h190, exp, what);
endtask

task automatic memory_tests();
  load_case(3'b000, 12'hffc, 32'h0000_00ff, 1'b1, "lb");
  load_case(3'b101, 12'h006, 32'h0000_ffff, 1'b0, "lhu");
  load_case(3'b010, 12'h008, 32'hffff_ffff, 1'b0, "lw");
  store_case(3'b000, 12'h003, 4'b0001, "sb");
  store_case(3'b001, 12'hffe, 4'b0011, "sh");
  store_case(3'b010, 12'h7f0, 4'b1111, "sw");
endtask

task automatic branch_case(input logic [2:0] f3, input logic [31:0] a, input logic [31:0] b,
                           input logic taken, input string what);
  logic [12:0] off;
  logic [31:0] imm;
  logic [31:0] target;
  off          = taken ? 13'h1ff0 : 13'h0040;
  imm          = {{19{off[12]}}, off};
  target       = taken ? 32'h200 + imm : 32'h204;
  reg_model[1] = a;
  reg_model[2] = b;
  send_inst(b_format(off, 5'd2, 5'd1, f3), 32'h200);
  compare_pc(dec_out.imm, imm, {what, " imm"});
  compare_pc(dec_out.pc_next, target, {what, " pc_next"});
  compare_flag(dec_out.reg_write, 1'b0, {what, " reg_write"});
endtask

task automatic branch_tests();
  branch_case(F3_BEQ, 32'd5, 32'd5, 1'b1, "beq taken");
  branch_case(F3_BEQ, 32'd5, 32'd6, 1'b0, "beq not taken");
  branch_case(F3_BNE, 32'd1, 32'd2, 1'b1, "bne taken");
  branch_case(F3_BNE, 32'd7, 32'd7, 1'b0, "bne not taken");
  // a negative operand orders differently signed and unsigned
  branch_case(F3_BLT, 32'hffff_fffd, 32'd2, 1'b1, "blt taken");
  branch_case(F3_BLT, 32'd2, 32'hffff_fffd, 1'b0, "blt not taken");
  branch_case(F3_BGE, 32'd2, 32'hffff_fffd, 1'b1, "bge taken");
  branch_case(F3_BGE, 32'hffff_fffd, 32'd2, 1'b0, "bge not taken");
  branch_case(F3_BLTU, 32'd2, 32'hffff_fffd, 1'b1, "bltu taken");
  branch_case(F3_BLTU, 32'hffff_fffd, 32'd2, 1'b0, "bltu not taken");
  branch_case(F3_BGEU, 32'hffff_fffd, 32'd2, 1'b1, "bgeu taken");
  branch_case(F3_BGEU, 32'd2, 32'hffff_fffd, 1'b0, "bgeu not taken");
endtask

task automatic jump_tests();
  dec_out_t    exp;
  logic [31:0] word;
  // backward jal
  exp = expect_alu(32'h1000, 32'h1000, 32'hffff_f800, 32'hffff_f800, 5'd1, ALU_ADD);
  exp.wd_sel  = WD_PC4;
  exp.pc_next = 32'h0000_0800;
  decode_check(j_format(21'h1ff800, 5'd1), 32'h1000, exp, "jal");
  // odd target, bit 0 must clear
  reg_model[5] = 32'h1000_0004;
  exp = expect_alu(32'h310, 32'h1000_0004, 32'h13, 32'h13, 5'd1, ALU_ADD);
  exp.wd_sel  = WD_PC4;
  exp.pc_next = 32'h1000_0016;
  decode_check(i_format(12'h013, 5'd5, 3'b000, 5'd1, OPC_JALR), 32'h310, exp, "jalr");
  word = u_format(20'habcde, 5'd3, OPC_LUI);
  run_alu(word, 32'h320, reg_model[word[19:15]], 32'habcd_e000, 32'habcd_e000, 5'd3,
          ALU_PASS_IMM, "lui");
  run_alu(u_format(20'h12345, 5'd4, OPC_AUIPC), 32'h330, 32'h330, 32'h1234_5000,
          32'h1234_5000, 5'd4, ALU_ADD, "auipc");
endtask

task automatic backpressure_test();
  dec_out_t    exp_a;
  dec_out_t    exp_b;
  dec_out_t    exp_c;
  logic [31:0] word_b;
  int          cycle_b;
  drain_slot();
  dec_ready = 1'b0;
  exp_a = expect_alu(32'h500, reg_model[1], 32'h11, 32'h11, 5'd20, ALU_ADD);
  decode_check(i_format(12'h011, 5'd1, 3'b000, 5'd20, OPC_OP_IMM), 32'h500, exp_a,
               "addi into stalled slot");
  exp_b       = expect_alu(32'h504, reg_model[2], reg_model[3], 32'h0, 5'd21, ALU_XOR);
  word_b      = r_format(7'h00, 5'd3, 5'd2, 3'b100, 5'd21);
  fetch_valid = 1'b1;
  fetch_inst  = word_b;
  fetch_pc    = 32'h504;
  repeat (4) begin
    @(negedge clk);
    compare_flag(fetch_ready, 1'b0, "inst_ready_o under back-pressure");
    compare_dec(dec_out, exp_a, "dec_o held under back-pressure");
    @(posedge clk);
    #1;
  end
  dec_ready = 1'b1;
  send_inst(word_b, 32'h504);
  compare_dec(dec_out, exp_b, "first item after stall");
  cycle_b = cycle_count;
  exp_c = expect_alu(32'h508, reg_model[4], 32'hffff_ff80, 32'hffff_ff80, 5'd22, ALU_OR);
  decode_check(i_format(12'hf80, 5'd4, 3'b110, 5'd22, OPC_OP_IMM), 32'h508, exp_c,
               "second item after stall");
  compare_flag(cycle_count == cycle_b + 1, 1'b1, "back-to-back items one cycle apart");
endtask

`endif

// File: verification/tb_idu.sv
// testbench for the decode stage with directed decode, branch and handshake tests
`timescale 1ns/1ps

module tb_idu import idu_pkg::*; ();

  // about 40 instructions at up to three cycles each plus stalls and reset
  localparam int TIMEOUT_CYCLES = 200;

  logic                  clk;
  logic                  rst;
  logic                  fetch_valid;
  logic [XLEN-1:0]       fetch_inst;
  logic [XLEN-1:0]       fetch_pc;
  logic                  fetch_ready;
  logic [REG_ADDR_W-1:0] rs1_addr;
  logic [REG_ADDR_W-1:0] rs2_addr;
  logic [XLEN-1:0]       rs1_data;
  logic [XLEN-1:0]       rs2_data;
  logic                  dec_valid;
  dec_out_t              dec_out;
  logic                  dec_ready;

  logic [XLEN-1:0] reg_model [32];
  int              seed = 10929;
  int              cycle_count = 0;

  always #4 clk = ~clk;

  // register file model answers in the same cycle
  assign rs1_data = reg_model[rs1_addr];
  assign rs2_data = reg_model[rs2_addr];

  idu u_idu (
    .clk          (clk),
    .rst          (rst),
    .inst_valid_i (fetch_valid),
    .inst_i       (fetch_inst),
    .pc_i         (fetch_pc),
    .inst_ready_o (fetch_ready),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .dec_valid_o  (dec_valid),
    .dec_o        (dec_out),
    .dec_ready_i  (dec_ready)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      fail_run($sformatf("timeout at %0t: tests still running after %0d cycles",
                         $time, TIMEOUT_CYCLES));
    end
  end

  `include "tb_idu_tasks.svh"

  initial begin
    clk         = 1'b0;
    rst         = 1'b1;
    fetch_valid = 1'b0;
    fetch_inst  = '0;
    fetch_pc    = '0;
    // execute stalled so ready after reset comes from the empty slot alone
    dec_ready   = 1'b0;
    for (int i = 0; i < 32; i++) begin
      reg_model[i] = $random(seed);
    end
    // x0 reads as zero
    reg_model[0] = '0;
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_check();
    dec_ready = 1'b1;
    itype_tests();
    rtype_tests();
    memory_tests();
    branch_tests();
    jump_tests();
    backpressure_test();
    $display("Result: PASSED");
    $finish;
  end

endmodule

// File: idu.f
+incdir+verification
design/idu_pkg.sv
design/imm_gen.sv
design/inst_decoder.sv
design/branch_unit.sv
design/idu.sv
verification/tb_idu.sv

// File: Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := tb_idu
FILELIST   := idu.f
BUILD_DIR  := obj_dir
SIM        := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# exit status follows the search for the pass line in the simulator output
run: build
	./$(SIM) | awk '{ print } /Result: PASSED/ { ok = 1 } END { exit !ok }'

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)
